// File: Bender.yml
package:
  name: mmc_host

sources:
  - design/mmc_link_pkg.sv
  - design/mmc_cmd_pkg.sv
  - design/mmc_bit_engine.sv
  - design/mmc_cmd_sequencer.sv
  - design/mmc_host_top.sv
  - target: test
    files:
      - testbench/mmc_host_props.sv
      - testbench/tb_mmc_host.sv

// File: design/mmc_bit_engine.sv
// MMC SPI bit engine

`timescale 1ns/1ps
`default_nettype none

module mmc_bit_engine
   import mmc_link_pkg::*, mmc_cmd_pkg::*;
(
   input  logic       clk,
   input  logic       mmc_reset,
   input  logic       speed,
   input  logic       eng_init,
   input  logic       eng_send,
   input  cmd_frame_u eng_cmd,
   input  logic       eng_wr,
   input  logic [7:0] eng_wr_data,
   input  logic       eng_rd,
   input  logic       eng_stop,
   output logic       eng_done,
   output logic [7:0] eng_rd_data,
   output logic       mmc_cs,
   output logic       mmc_do,
   output logic       mmc_sclk,
   input  logic       mmc_di
);

   logic [3:0]  state;
   logic [3:0]  state_nxt;
   logic        speed_q;
   logic [15:0] bit_time;
   logic [15:0] bit_w;
   logic [15:0] mid_cnt;
   logic [15:0] end_cnt;
   logic        bit_mid;
   logic        bit_end;
   logic        q_win;
   logic        hi_win;
   logic [7:0]  bitcount;
   logic [7:0]  bit_limit;
   logic        bit_run;
   logic        sclk_run;
   logic        op_last;
   logic [47:0] shreg;
   logic [7:0]  byte_src;

   //////////////////////////////////////////////////
   // Bit timing

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         speed_q <= 1'b0;
      end else begin
         speed_q <= speed;
      end
   end

   assign bit_w   = speed_q ? BIT_HI : BIT_LO;
   assign mid_cnt = bit_w >> 1;
   assign end_cnt = bit_w - 16'd1;

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         bit_time <= '0;
      end else if (!bit_run || bit_end) begin
         bit_time <= '0;
      end else begin
         bit_time <= bit_time + 16'd1;
      end
   end

   // Strobes within a card bit
   assign bit_mid = (bit_time == mid_cnt);
   assign bit_end = (bit_time >= end_cnt);
   assign q_win   = (bit_time >= BIT_LO_Q1) && (bit_time < BIT_LO_Q3);
   assign hi_win  = (bit_time >= mid_cnt - 16'd1) && (bit_time < end_cnt);

   // States that time bits, and the subset that also clocks sclk
   assign bit_run  = (state == ENG_CMD1) || (state == ENG_WR) || (state == ENG_RD) ||
                     (state == ENG_INIT0) || (state == ENG_INIT1) || (state == ENG_STP1);
   assign sclk_run = bit_run && (state != ENG_INIT1);

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         bitcount <= '0;
      end else if (!bit_run) begin
         bitcount <= '0;
      end else if (bit_end) begin
         bitcount <= bitcount + 8'd1;
      end
   end

   always_comb begin
      case (state)
         ENG_CMD1:                    bit_limit = FRAME_BITS;
         ENG_WR, ENG_RD, ENG_STP1:    bit_limit = BYTE_BITS;
         ENG_INIT0:                   bit_limit = INIT_CLOCKS;
         ENG_INIT1:                   bit_limit = INIT_BITS;
         default:                     bit_limit = 8'd0;
      endcase
   end

   assign op_last = bit_end && (bitcount == bit_limit - 8'd1);

   //////////////////////////////////////////////////
   // State machine

   always_comb begin
      state_nxt = state;
      case (state)
         ENG_IDLE: begin
            if (eng_init) begin
               state_nxt = ENG_INIT0;
            end else if (eng_send) begin
               state_nxt = ENG_CMD0;
            end else if (eng_wr) begin
               state_nxt = ENG_WR;
            end else if (eng_rd) begin
               state_nxt = ENG_RD;
            end else if (eng_stop) begin
               state_nxt = ENG_STP0;
            end
         end
         ENG_CMD0:  state_nxt = ENG_CMD1;
         ENG_CMD1, ENG_WR, ENG_RD, ENG_STP1, ENG_INIT1: begin
            if (op_last) begin
               state_nxt = ENG_DONE0;
            end
         end
         ENG_INIT0: begin
            if (op_last) begin
               state_nxt = ENG_INIT1;
            end
         end
         ENG_STP0:  state_nxt = ENG_STP1;
         ENG_DONE0: state_nxt = ENG_DONE1;
         ENG_DONE1: state_nxt = ENG_DONE2;
         default:   state_nxt = ENG_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         state <= ENG_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign eng_done = (state == ENG_IDLE);

   //////////////////////////////////////////////////
   // Card pins

   // One sclk pulse per bit, falling again at the end of the bit
   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         mmc_sclk <= 1'b0;
      end else begin
         mmc_sclk <= sclk_run && (speed_q ? hi_win : q_win);
      end
   end

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         mmc_cs <= 1'b0;
         mmc_do <= 1'b0;
      end else begin
         case (state)
            ENG_CMD0: begin
               mmc_cs <= 1'b0;
               mmc_do <= shreg[47];
            end
            ENG_CMD1, ENG_WR, ENG_RD: mmc_do <= shreg[47];
            ENG_INIT0, ENG_STP0: begin
               mmc_cs <= 1'b1;
               mmc_do <= 1'b1;
            end
            ENG_INIT1, ENG_DONE0: mmc_do <= 1'b1;
            default: ;
         endcase
      end
   end

   // Reads clock out all ones
   assign byte_src = eng_wr ? eng_wr_data : IDLE_BYTE;

   // MSB first out, fill with ones behind
   always_ff @(posedge clk) begin
      if (state == ENG_IDLE) begin
         if (eng_send) begin
            shreg <= eng_cmd.raw;
         end else begin
            shreg <= {byte_src, {40{1'b1}}};
         end
      end else if (bit_end && ((state == ENG_CMD1) || (state == ENG_WR))) begin
         shreg <= {shreg[46:0], 1'b1};
      end
   end

   // Sample di at mid-bit while sclk is high
   always_ff @(posedge clk) begin
      if ((state == ENG_RD) && bit_mid) begin
         eng_rd_data <= {eng_rd_data[6:0], mmc_di};
      end
   end

endmodule

`default_nettype wire

// File: design/mmc_cmd_pkg.sv
// Command frame definitions

`default_nettype none

package mmc_cmd_pkg;

   //////////////////////////////////////////////////
   // 48-bit command frame

   typedef union packed {
      logic [47:0] raw;
      struct packed {
         logic [1:0]  start_bits;
         logic [5:0]  index;
         logic [31:0] arg;
         logic [6:0]  crc7;
         logic        end_bit;
      } fld;
   } cmd_frame_u;

   localparam logic [7:0] FRAME_BITS = 8'd48;
   localparam logic [1:0] START_BITS = 2'b01;
   localparam logic       END_BIT    = 1'b1;

   // x^7 + x^3 + 1
   localparam logic [6:0] CRC7_POLY = 7'h09;

   // Response polling
   localparam logic [3:0] RESP_POLL_MAX = 4'd8;
   localparam logic [7:0] IDLE_BYTE     = 8'hFF;

   //////////////////////////////////////////////////
   // Sequencer states

   localparam logic [1:0] SEQ_IDLE    = 2'd0;
   localparam logic [1:0] SEQ_WAIT_LO = 2'd1;
   localparam logic [1:0] SEQ_WAIT_HI = 2'd2;
   localparam logic [1:0] SEQ_FINISH  = 2'd3;

endpackage

`default_nettype wire

// File: design/mmc_cmd_sequencer.sv
// MMC command sequencer

`timescale 1ns/1ps
`default_nettype none

module mmc_cmd_sequencer
   import mmc_cmd_pkg::*;
(
   input  logic        clk,
   input  logic        mmc_reset,
   input  logic        init_req,
   input  logic        cmd_req,
   input  logic [5:0]  cmd_index,
   input  logic [31:0] cmd_arg,
   input  logic        wr_req,
   input  logic [7:0]  wr_data,
   input  logic        rd_req,
   input  logic        stop_req,
   input  logic        eng_done,
   input  logic [7:0]  eng_rd_data,
   output logic        busy,
   output logic [7:0]  resp,
   output logic        resp_valid,
   output logic        resp_timeout,
   output logic [7:0]  rd_data,
   output logic        rd_valid,
   output logic        eng_init,
   output logic        eng_send,
   output cmd_frame_u  eng_cmd,
   output logic        eng_wr,
   output logic [7:0]  eng_wr_data,
   output logic        eng_rd,
   output logic        eng_stop
);

   logic [1:0] seq_state;
   logic       req_ok;
   logic       op_cmd;
   logic       op_rd;
   logic       polling;
   logic [3:0] poll_cnt;
   logic [6:0] frame_crc;

   // CRC7 over start bits, index and argument, MSB first
   function automatic logic [6:0] crc7_calc(input logic [39:0] data);
      logic [6:0] crc;
      logic       fb;
      crc = '0;
      for (int i = 39; i >= 0; i--) begin
         fb  = data[i] ^ crc[6];
         crc = {crc[5:0], 1'b0};
         if (fb) begin
            crc = crc ^ CRC7_POLY;
         end
      end
      return crc;
   endfunction

   assign req_ok    = !busy && (init_req || cmd_req || wr_req || rd_req || stop_req);
   assign frame_crc = crc7_calc({START_BITS, cmd_index, cmd_arg});

   //////////////////////////////////////////////////
   // Request payloads and results

   always_ff @(posedge clk) begin
      if (!busy && cmd_req) begin
         eng_cmd.fld.start_bits <= START_BITS;
         eng_cmd.fld.index      <= cmd_index;
         eng_cmd.fld.arg        <= cmd_arg;
         eng_cmd.fld.crc7       <= frame_crc;
         eng_cmd.fld.end_bit    <= END_BIT;
      end
      if (!busy && wr_req) begin
         eng_wr_data <= wr_data;
      end
      if ((seq_state == SEQ_WAIT_HI) && eng_done) begin
         if (polling) begin
            resp <= eng_rd_data;
         end
         if (op_rd) begin
            rd_data <= eng_rd_data;
         end
      end
   end

   //////////////////////////////////////////////////
   // Control FSM

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         seq_state    <= SEQ_IDLE;
         busy         <= 1'b0;
         resp_valid   <= 1'b0;
         resp_timeout <= 1'b0;
         rd_valid     <= 1'b0;
         eng_init     <= 1'b0;
         eng_send     <= 1'b0;
         eng_wr       <= 1'b0;
         eng_rd       <= 1'b0;
         eng_stop     <= 1'b0;
         op_cmd       <= 1'b0;
         op_rd        <= 1'b0;
         polling      <= 1'b0;
         poll_cnt     <= '0;
      end else begin
         // Pulses last one clock
         resp_valid   <= 1'b0;
         resp_timeout <= 1'b0;
         rd_valid     <= 1'b0;
         eng_init     <= 1'b0;
         eng_send     <= 1'b0;
         eng_wr       <= 1'b0;
         eng_rd       <= 1'b0;
         eng_stop     <= 1'b0;
         case (seq_state)
            SEQ_IDLE: begin
               if (req_ok) begin
                  busy      <= 1'b1;
                  seq_state <= SEQ_WAIT_LO;
                  polling   <= 1'b0;
                  op_cmd    <= !init_req && cmd_req;
                  op_rd     <= !init_req && !cmd_req && !wr_req && rd_req;
                  if (init_req) begin
                     eng_init <= 1'b1;
                  end else if (cmd_req) begin
                     eng_send <= 1'b1;
                  end else if (wr_req) begin
                     eng_wr <= 1'b1;
                  end else if (rd_req) begin
                     eng_rd <= 1'b1;
                  end else begin
                     eng_stop <= 1'b1;
                  end
               end
            end
            // Engine has taken the request once done drops
            SEQ_WAIT_LO: begin
               if (!eng_done) begin
                  seq_state <= SEQ_WAIT_HI;
               end
            end
            SEQ_WAIT_HI: begin
               if (eng_done) begin
                  if (op_cmd && !polling) begin
                     polling   <= 1'b1;
                     poll_cnt  <= '0;
                     eng_rd    <= 1'b1;
                     seq_state <= SEQ_WAIT_LO;
                  end else if (polling) begin
                     if (!eng_rd_data[7] || (poll_cnt == RESP_POLL_MAX - 4'd1)) begin
                        resp_valid   <= 1'b1;
                        resp_timeout <= eng_rd_data[7];
                        seq_state    <= SEQ_FINISH;
                     end else begin
                        poll_cnt  <= poll_cnt + 4'd1;
                        eng_rd    <= 1'b1;
                        seq_state <= SEQ_WAIT_LO;
                     end
                  end else if (op_rd) begin
                     rd_valid  <= 1'b1;
                     seq_state <= SEQ_FINISH;
                  end else begin
                     // init, write and stop have no result
                     busy      <= 1'b0;
                     seq_state <= SEQ_IDLE;
                  end
               end
            end
            default: begin
               busy      <= 1'b0;
               seq_state <= SEQ_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/mmc_host_top.sv
// MMC SPI host controller top

`timescale 1ns/1ps
`default_nettype none

module mmc_host_top
   import mmc_cmd_pkg::*;
(
   input  logic        clk,
   input  logic        mmc_reset,
   input  logic        speed,
   input  logic        init_req,
   input  logic        cmd_req,
   input  logic [5:0]  cmd_index,
   input  logic [31:0] cmd_arg,
   input  logic        wr_req,
   input  logic [7:0]  wr_data,
   input  logic        rd_req,
   input  logic        stop_req,
   output logic        busy,
   output logic [7:0]  resp,
   output logic        resp_valid,
   output logic        resp_timeout,
   output logic [7:0]  rd_data,
   output logic        rd_valid,
   output logic        mmc_cs,
   output logic        mmc_do,
   output logic        mmc_sclk,
   input  logic        mmc_di
);

   //////////////////////////////////////////////////
   // Sequencer to engine

   logic       eng_init;
   logic       eng_send;
   cmd_frame_u eng_cmd;
   logic       eng_wr;
   logic [7:0] eng_wr_data;
   logic       eng_rd;
   logic       eng_stop;
   logic       eng_done;
   logic [7:0] eng_rd_data;

   mmc_cmd_sequencer mmc_cmd_sequencer_inst (
      .clk          (clk),
      .mmc_reset    (mmc_reset),
      .init_req     (init_req),
      .cmd_req      (cmd_req),
      .cmd_index    (cmd_index),
      .cmd_arg      (cmd_arg),
      .wr_req       (wr_req),
      .wr_data      (wr_data),
      .rd_req       (rd_req),
      .stop_req     (stop_req),
      .eng_done     (eng_done),
      .eng_rd_data  (eng_rd_data),
      .busy         (busy),
      .resp         (resp),
      .resp_valid   (resp_valid),
      .resp_timeout (resp_timeout),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .eng_init     (eng_init),
      .eng_send     (eng_send),
      .eng_cmd      (eng_cmd),
      .eng_wr       (eng_wr),
      .eng_wr_data  (eng_wr_data),
      .eng_rd       (eng_rd),
      .eng_stop     (eng_stop)
   );

   mmc_bit_engine mmc_bit_engine_inst (
      .clk         (clk),
      .mmc_reset   (mmc_reset),
      .speed       (speed),
      .eng_init    (eng_init),
      .eng_send    (eng_send),
      .eng_cmd     (eng_cmd),
      .eng_wr      (eng_wr),
      .eng_wr_data (eng_wr_data),
      .eng_rd      (eng_rd),
      .eng_stop    (eng_stop),
      .eng_done    (eng_done),
      .eng_rd_data (eng_rd_data),
      .mmc_cs      (mmc_cs),
      .mmc_do      (mmc_do),
      .mmc_sclk    (mmc_sclk),
      .mmc_di      (mmc_di)
   );

endmodule

`default_nettype wire

// File: design/mmc_link_pkg.sv
// SPI link timing definitions

`default_nettype none

package mmc_link_pkg;

   //////////////////////////////////////////////////
   // Clock rates

   localparam logic [31:0] CLK_FREQ = 32'd50_000_000;
   localparam logic [31:0] RATE_HI  = 32'd10_000_000;
   localparam logic [31:0] RATE_LO  = 32'd100_000;

   // System clocks per card bit
   localparam logic [15:0] BIT_HI    = 16'(CLK_FREQ / RATE_HI);
   localparam logic [15:0] BIT_LO    = 16'(CLK_FREQ / RATE_LO);
   // Slow sclk is high between the quarter points
   localparam logic [15:0] BIT_LO_Q1 = BIT_LO / 16'd4;
   localparam logic [15:0] BIT_LO_Q3 = BIT_LO - BIT_LO_Q1;

   // Bit counts per sequence
   localparam logic [7:0] INIT_CLOCKS = 8'd80;
   localparam logic [7:0] INIT_BITS   = 8'd100;
   localparam logic [7:0] BYTE_BITS   = 8'd8;

   //////////////////////////////////////////////////
   // Engine states

   localparam logic [3:0] ENG_IDLE  = 4'd0;
   localparam logic [3:0] ENG_CMD0  = 4'd4;
   localparam logic [3:0] ENG_CMD1  = 4'd5;
   localparam logic [3:0] ENG_WR    = 4'd6;
   localparam logic [3:0] ENG_RD    = 4'd7;
   localparam logic [3:0] ENG_INIT0 = 4'd8;
   localparam logic [3:0] ENG_INIT1 = 4'd9;
   localparam logic [3:0] ENG_STP0  = 4'd10;
   localparam logic [3:0] ENG_STP1  = 4'd11;
   localparam logic [3:0] ENG_DONE0 = 4'd12;
   localparam logic [3:0] ENG_DONE1 = 4'd13;
   localparam logic [3:0] ENG_DONE2 = 4'd14;

endpackage

`default_nettype wire

// File: flist.f
design/mmc_link_pkg.sv
design/mmc_cmd_pkg.sv
design/mmc_bit_engine.sv
design/mmc_cmd_sequencer.sv
design/mmc_host_top.sv
testbench/mmc_host_props.sv
testbench/tb_mmc_host.sv

// File: testbench/mmc_host_props.sv
// SPI host assertions

`timescale 1ns/1ps
`default_nettype none

module mmc_host_props
   import mmc_link_pkg::*;
(
   input logic       clk,
   input logic       mmc_reset,
   input logic [3:0] eng_state,
   input logic       mmc_sclk,
   input logic       mmc_cs,
   input logic       busy,
   input logic       resp_valid
);

   int fail_count = 0;

   // No card clock while the engine is idle
   sclk_idle_low: assert property (@(posedge clk) disable iff (mmc_reset)
      (eng_state == ENG_IDLE) |-> !mmc_sclk)
      else begin
         fail_count++;
         $error("mmc_sclk high while the engine is idle");
      end

   resp_in_busy: assert property (@(posedge clk) disable iff (mmc_reset)
      resp_valid |-> busy)
      else begin
         fail_count++;
         $error("resp_valid outside of busy");
      end

   // Power-up clocks only with cs high
   cs_high_init: assert property (@(posedge clk) disable iff (mmc_reset)
      ((eng_state == ENG_INIT0) && mmc_sclk) |-> mmc_cs)
      else begin
         fail_count++;
         $error("mmc_cs low during the power-up clocks");
      end

endmodule

bind mmc_host_top mmc_host_props mmc_host_props_inst (
   .clk        (clk),
   .mmc_reset  (mmc_reset),
   .eng_state  (mmc_bit_engine_inst.state),
   .mmc_sclk   (mmc_sclk),
   .mmc_cs     (mmc_cs),
   .busy       (busy),
   .resp_valid (resp_valid)
);

`default_nettype wire

// File: testbench/tb_mmc_host.sv
// MMC host controller testbench

`timescale 1ns/1ps
`default_nettype none

module tb_mmc_host
   import mmc_cmd_pkg::*;
();

   localparam int WAIT_LIMIT = 200000;
   localparam int W_IDLE     = 0;
   localparam int W_RESP     = 1;
   localparam int W_RDV      = 2;

   logic        clk;
   logic        mmc_reset;
   logic        speed;
   logic        init_req;
   logic        cmd_req;
   logic [5:0]  cmd_index;
   logic [31:0] cmd_arg;
   logic        wr_req;
   logic [7:0]  wr_data;
   logic        rd_req;
   logic        stop_req;
   logic        busy;
   logic [7:0]  resp;
   logic        resp_valid;
   logic        resp_timeout;
   logic [7:0]  rd_data;
   logic        rd_valid;
   logic        mmc_cs;
   logic        mmc_do;
   logic        mmc_sclk;
   logic        mmc_di;

   // Card model state
   logic [47:0] rx_shift;
   logic [47:0] frame_cap;
   logic        frame_armed;
   int          rx_bits;
   int          hi_edges;
   int          hi_do_low;
   logic [7:0]  tx_byte;
   int          tx_bits;
   logic [7:0]  tx_q[$];
   logic [7:0]  resp_q[$];

   logic [31:0] rng_state;
   int          errors;
   int          timeouts;
   logic        aborted;
   int          assert_fails;

   mmc_host_top mmc_host_top_inst (
      .clk          (clk),
      .mmc_reset    (mmc_reset),
      .speed        (speed),
      .init_req     (init_req),
      .cmd_req      (cmd_req),
      .cmd_index    (cmd_index),
      .cmd_arg      (cmd_arg),
      .wr_req       (wr_req),
      .wr_data      (wr_data),
      .rd_req       (rd_req),
      .stop_req     (stop_req),
      .busy         (busy),
      .resp         (resp),
      .resp_valid   (resp_valid),
      .resp_timeout (resp_timeout),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .mmc_cs       (mmc_cs),
      .mmc_do       (mmc_do),
      .mmc_sclk     (mmc_sclk),
      .mmc_di       (mmc_di)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // SPI card model

   always @(posedge mmc_sclk) begin
      if (!mmc_reset && mmc_cs) begin
         hi_edges++;
         if (!mmc_do) begin
            hi_do_low++;
         end
      end else if (!mmc_reset && !mmc_cs) begin
         rx_shift = {rx_shift[46:0], mmc_do};
         rx_bits++;
         // Response bytes only follow a complete frame
         if (frame_armed && (rx_bits == 48)) begin
            frame_cap   = rx_shift;
            frame_armed = 1'b0;
            while (resp_q.size() > 0) begin
               tx_q.push_back(resp_q.pop_front());
            end
         end
      end
   end

   always @(negedge mmc_sclk) begin
      if (!mmc_reset && !mmc_cs) begin
         tx_bits++;
         if (tx_bits == 8) begin
            tx_bits = 0;
            if (tx_q.size() > 0) begin
               tx_byte = tx_q.pop_front();
            end else begin
               tx_byte = 8'hFF;
            end
         end else begin
            tx_byte = {tx_byte[6:0], 1'b1};
         end
      end
   end

   assign mmc_di = tx_byte[7];

   //////////////////////////////////////////////////
   // Helpers and reference model

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic expect_equal(input string what, input logic [47:0] got,
                               input logic [47:0] exp);
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Remainder of msg * x^7 divided by x^7 + x^3 + 1
   function automatic logic [6:0] model_crc7(input logic [39:0] msg);
      logic [46:0] rem;
      rem = {msg, 7'b0};
      for (int i = 46; i >= 7; i--) begin
         if (rem[i]) begin
            rem[i -: 8] = rem[i -: 8] ^ 8'h89;
         end
      end
      return rem[6:0];
   endfunction

   function automatic logic [47:0] model_frame(input logic [5:0] idx, input logic [31:0] arg);
      return {2'b01, idx, arg, model_crc7({2'b01, idx, arg}), 1'b1};
   endfunction

   task automatic wait_status(input int what, input string label);
      int   n;
      logic hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && !aborted) begin
         next_cycle();
         n++;
         case (what)
            W_IDLE:  hit = !busy;
            W_RESP:  hit = resp_valid;
            default: hit = rd_valid;
         endcase
         if (!hit && (n >= WAIT_LIMIT)) begin
            $display("timeout: no %s within %0d clock cycles", label, WAIT_LIMIT);
            timeouts++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic card_load(input logic [7:0] data);
      tx_q.delete();
      tx_byte = data;
      tx_bits = 0;
   endtask

   //////////////////////////////////////////////////
   // Operations

   // Init and stop both clock with cs and do high
   task automatic run_idle_clocks(input logic do_init, input int exp_edges);
      hi_edges  = 0;
      hi_do_low = 0;
      rx_bits   = 0;
      init_req  = do_init;
      stop_req  = !do_init;
      next_cycle();
      init_req  = 1'b0;
      stop_req  = 1'b0;
      wait_status(W_IDLE, "end of init or stop");
      expect_equal("sclk edges with cs high", hi_edges, exp_edges);
      expect_equal("do low bits with cs high", hi_do_low, 0);
      expect_equal("sclk edges with cs low", rx_bits, 0);
   endtask

   task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg, input int fill,
                          input logic [7:0] answer);
      logic [7:0] exp_resp;
      logic       exp_timeout;
      if (fill < RESP_POLL_MAX) begin
         exp_resp    = answer;
         exp_timeout = 1'b0;
      end else begin
         exp_resp    = 8'hFF;
         exp_timeout = 1'b1;
      end
      card_load(8'hFF);
      resp_q.delete();
      repeat (fill) resp_q.push_back(8'hFF);
      resp_q.push_back(answer);
      rx_bits     = 0;
      frame_armed = 1'b1;
      cmd_index   = idx;
      cmd_arg     = arg;
      cmd_req     = 1'b1;
      next_cycle();
      cmd_req     = 1'b0;
      wait_status(W_RESP, "resp_valid");
      expect_equal("command frame", frame_cap, model_frame(idx, arg));
      expect_equal("resp", resp, exp_resp);
      expect_equal("resp_timeout", resp_timeout, exp_timeout);
      wait_status(W_IDLE, "end of command");
   endtask

   task automatic run_write(input logic [7:0] data);
      rx_bits = 0;
      wr_data = data;
      wr_req  = 1'b1;
      next_cycle();
      wr_req  = 1'b0;
      wait_status(W_IDLE, "end of write");
      expect_equal("written bit count", rx_bits, 8);
      expect_equal("written byte", rx_shift[7:0], data);
   endtask

   task automatic run_read(input logic [7:0] data);
      card_load(data);
      rd_req = 1'b1;
      next_cycle();
      rd_req = 1'b0;
      wait_status(W_RDV, "rd_valid");
      expect_equal("read byte", rd_data, data);
      wait_status(W_IDLE, "end of read");
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial begin
      int          fill;
      logic [31:0] r;
      clk         = 1'b0;
      mmc_reset   = 1'b1;
      speed       = 1'b0;
      init_req    = 1'b0;
      cmd_req     = 1'b0;
      cmd_index   = '0;
      cmd_arg     = '0;
      wr_req      = 1'b0;
      wr_data     = '0;
      rd_req      = 1'b0;
      stop_req    = 1'b0;
      rng_state   = 32'h71649d5a;
      errors      = 0;
      timeouts    = 0;
      aborted     = 1'b0;
      rx_shift    = '1;
      frame_cap   = '0;
      frame_armed = 1'b0;
      rx_bits     = 0;
      hi_edges    = 0;
      hi_do_low   = 0;
      tx_byte     = 8'hFF;
      tx_bits     = 0;
      repeat (2) next_cycle();
      mmc_reset = 1'b0;

      expect_equal("busy after reset", busy, 1'b0);
      expect_equal("resp_valid after reset", resp_valid, 1'b0);
      expect_equal("rd_valid after reset", rd_valid, 1'b0);
      expect_equal("mmc_sclk after reset", mmc_sclk, 1'b0);
      expect_equal("mmc_cs after reset", mmc_cs, 1'b0);

      // Power-up clocks run at the slow rate
      run_idle_clocks(1'b1, 80);

      speed = 1'b1;
      next_cycle();
      for (int k = 0; k < 12; k++) begin
         r    = next_rand();
         fill = int'(next_rand() % 32'd11);
         // Make sure both the timeout and the quick answer occur
         if (k == 0) begin
            fill = 10;
         end else if (k == 1) begin
            fill = 0;
         end
         run_cmd(r[29:24], next_rand(), fill, {1'b0, r[6:0]});
      end

      // Byte transfers, fast first and then slow
      for (int s = 1; s >= 0; s--) begin
         speed = s[0];
         next_cycle();
         for (int k = 0; k < 4; k++) begin
            r = next_rand();
            run_write(r[15:8]);
            run_read(r[23:16]);
         end
      end

      run_idle_clocks(1'b0, 8);

      assert_fails = mmc_host_top_inst.mmc_host_props_inst.fail_count;
      $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, assert_fails);
      if ((errors == 0) && (timeouts == 0) && (assert_fails == 0)) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
